// File: common/zx_consts.svh
`ifndef ZX_CONSTS_SVH
`define ZX_CONSTS_SVH

// io port map
`define ZX_PORT_FE       8'hFE
`define ZX_PORT_SYSCONF  16'h20AF

// opcode fetches from this high byte trap into dos
`define ZX_DOS_TRAP_HI   8'h3D

// fixed ram pages of the windows at 4000 and 8000
`define ZX_RAM_WIN1      8'd5
`define ZX_RAM_WIN2      8'd2

// rom page mapped at 0000 while vdos is active
`define ZX_VDOS_ROM_PAGE 8'd4

// interrupt period and pulse length, in fclk cycles
`define ZX_FRAME_LEN     200
`define ZX_INT_LEN       32

// flops in the z80 pin synchroniser
`define ZX_SYNC_STAGES   2

`endif

// File: common/zx_pkg.sv
`default_nettype none

package zx_pkg;

	// z80 bus after the synchroniser, flags active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        iorq;
		logic        mreq;
		logic        rd;
		logic        wr;
		logic        m1;
	} z80_bus_t;

	// single-cycle access pulses
	typedef struct packed {
		logic io_wr;
		logic io_rd;
		logic mem_rd;
		logic m1_fetch;
		logic int_ack;
	} z80_strobe_t;

	// configuration registers written through io ports
	typedef struct packed {
		logic [2:0] border;
		logic       beep;
		logic [2:0] ram_page;
		logic       screen;
		logic       rom_sel;
		logic       lock;
		logic [1:0] turbo;
		logic       vdrive;
	} zx_regs_t;

	typedef enum logic [1:0] {
		ST_BASIC,
		ST_DOS,
		ST_VDOS
	} dos_state_t;

	typedef enum logic [2:0] {
		PORT_NONE,
		PORT_FE,
		PORT_7FFD,
		PORT_SYSCONF,
		PORT_FDC
	} port_sel_t;

endpackage

`default_nettype wire

// File: logic/zsignals.sv
`default_nettype none

`include "zx_consts.svh"

module zsignals import zx_pkg::*; (
	input  logic        fclk,
	input  logic        arst_n,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	output z80_bus_t    bus,
	output z80_strobe_t strobe
);

	z80_bus_t   raw;
	z80_bus_t   sync_q [`ZX_SYNC_STAGES];
	logic [4:0] cond;
	logic [4:0] cond_q;

	// pins inverted to active-high flags
	assign raw = '{addr: a, data: d_in, iorq: ~iorq_n, mreq: ~mreq_n,
		rd: ~rd_n, wr: ~wr_n, m1: ~m1_n};

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ZX_SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= raw;
			for (int i = 1; i < `ZX_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign bus = sync_q[`ZX_SYNC_STAGES-1];

	// same bit order as z80_strobe_t
	assign cond = {bus.iorq & bus.wr, bus.iorq & bus.rd, bus.mreq & bus.rd,
		bus.mreq & bus.m1, bus.iorq & bus.m1};

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			cond_q <= '0;
		end else begin
			cond_q <= cond;
		end
	end

	// rising edge of each condition
	assign strobe = z80_strobe_t'(cond & ~cond_q);

endmodule

`default_nettype wire

// File: ports/zports.sv
`default_nettype none

`include "zx_consts.svh"

module zports import zx_pkg::*; (
	input  logic        fclk,
	input  logic        arst_n,
	input  z80_bus_t    bus,
	input  z80_strobe_t strobe,
	input  dos_state_t  dos_state,
	output zx_regs_t    regs,
	output logic [7:0]  d_out,
	output logic        d_oe,
	output logic        vdos_on
);

	port_sel_t sel;
	logic      io_access;
	logic      readable;
	logic      rd_active;

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	always_comb begin
		sel = PORT_NONE;
		if (bus.addr[7:0] == `ZX_PORT_FE) begin
			sel = PORT_FE;
		end else if (bus.addr == `ZX_PORT_SYSCONF) begin
			sel = PORT_SYSCONF;
		end else if (!bus.addr[15] && !bus.addr[1]) begin
			// partial decode, as on the 128k machines
			sel = PORT_7FFD;
		end else if (bus.addr[7:0] inside {8'h1F, 8'h3F, 8'h5F, 8'h7F, 8'hFF}) begin
			sel = PORT_FDC;
		end
	end

	////////////////////////////////////////
	// configuration registers
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '0;
		end else if (strobe.io_wr) begin
			case (sel)
				PORT_FE: begin
					regs.border <= bus.data[2:0];
					regs.beep   <= bus.data[4];
				end
				PORT_7FFD: begin
					// locked until reset
					if (!regs.lock) begin
						regs.ram_page <= bus.data[2:0];
						regs.screen   <= bus.data[3];
						regs.rom_sel  <= bus.data[4];
						regs.lock     <= bus.data[5];
					end
				end
				PORT_SYSCONF: begin
					regs.turbo  <= bus.data[1:0];
					regs.vdrive <= bus.data[7];
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////////////////////////
	// readback and vdos trigger
	////////////////////////////////////////

	assign io_access = strobe.io_rd | strobe.io_wr;

	// only sysconf reads back
	assign readable  = (sel == PORT_SYSCONF);
	assign rd_active = bus.iorq & bus.rd & readable;

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			d_oe    <= 1'b0;
			d_out   <= 8'h00;
			vdos_on <= 1'b0;
		end else begin
			d_oe <= rd_active;
			if (rd_active) begin
				d_out <= {regs.vdrive, 5'b00000, regs.turbo};
			end
			// any fdc access from dos with a virtual drive enabled
			vdos_on <= io_access && (sel == PORT_FDC) &&
				(dos_state == ST_DOS) && regs.vdrive;
		end
	end

endmodule

`default_nettype wire

// File: memory/zpager.sv
`default_nettype none

`include "zx_consts.svh"

module zpager import zx_pkg::*; (
	input  logic        fclk,
	input  logic        arst_n,
	input  z80_bus_t    bus,
	input  z80_strobe_t strobe,
	input  zx_regs_t    regs,
	input  dos_state_t  dos_state,
	output logic [7:0]  page,
	output logic        romnram,
	output logic        dos_on,
	output logic        dos_off
);

	logic [1:0] win;
	logic [7:0] page_next;
	logic       romnram_next;

	assign win = bus.addr[15:14];

	// window 0 is rom, the rest is ram
	always_comb begin
		romnram_next = 1'b0;
		case (win)
			2'd0: begin
				romnram_next = 1'b1;
				if (dos_state == ST_VDOS) begin
					page_next = `ZX_VDOS_ROM_PAGE;
				end else begin
					page_next = {6'b000000, dos_state == ST_DOS, regs.rom_sel};
				end
			end
			2'd1: page_next = `ZX_RAM_WIN1;
			2'd2: page_next = `ZX_RAM_WIN2;
			default: page_next = {5'b00000, regs.ram_page};
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			page    <= 8'h00;
			romnram <= 1'b1;
			dos_on  <= 1'b0;
			dos_off <= 1'b0;
		end else begin
			// hold mapping between memory cycles
			if (bus.mreq) begin
				page    <= page_next;
				romnram <= romnram_next;
			end
			dos_on  <= strobe.m1_fetch && (win == 2'd0) &&
				(bus.addr[15:8] == `ZX_DOS_TRAP_HI) && regs.rom_sel;
			// leaving rom ends dos
			dos_off <= strobe.m1_fetch && (win != 2'd0);
		end
	end

endmodule

`default_nettype wire

// File: memory/zdos.sv
`default_nettype none

module zdos import zx_pkg::*; (
	input  logic       fclk,
	input  logic       arst_n,
	input  logic       dos_on,
	input  logic       dos_off,
	input  logic       vdos_on,
	output dos_state_t dos_state
);

	dos_state_t state_next;

	always_comb begin
		state_next = dos_state;
		case (dos_state)
			ST_BASIC: begin
				if (dos_on) begin
					state_next = ST_DOS;
				end
			end
			ST_DOS: begin
				// exit wins over the vdos request
				if (dos_off) begin
					state_next = ST_BASIC;
				end else if (vdos_on) begin
					state_next = ST_VDOS;
				end
			end
			ST_VDOS: begin
				if (dos_off) begin
					state_next = ST_BASIC;
				end
			end
			default: state_next = ST_BASIC;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			dos_state <= ST_BASIC;
		end else begin
			dos_state <= state_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/zint.sv
`default_nettype none

`include "zx_consts.svh"

module zint import zx_pkg::*; (
	input  logic        fclk,
	input  logic        arst_n,
	input  z80_strobe_t strobe,
	output logic        int_n
);

	logic [$clog2(`ZX_FRAME_LEN)-1:0] frame_cnt;
	logic [$clog2(`ZX_INT_LEN)-1:0]   int_cnt;
	logic                             frame_end;
	logic                             int_end;

	assign frame_end = (int'(frame_cnt) == `ZX_FRAME_LEN - 1);
	assign int_end   = (int'(int_cnt) == `ZX_INT_LEN - 1);

	// frame counter, free running
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			frame_cnt <= '0;
		end else if (frame_end) begin
			frame_cnt <= '0;
		end else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// interrupt pulse and its length
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			int_n   <= 1'b1;
			int_cnt <= '0;
		end else if (frame_end) begin
			int_n   <= 1'b0;
			int_cnt <= '0;
		end else if (!int_n) begin
			// acknowledge cuts the pulse short
			if (int_end || strobe.int_ack) begin
				int_n <= 1'b1;
			end
			int_cnt <= int_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/zx_top.sv
`default_nettype none

module zx_top import zx_pkg::*; (
	input  logic        fclk,
	input  logic        arst_n,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	output logic [7:0]  d_out,
	output logic        d_oe,
	output logic        int_n,
	output logic [7:0]  page,
	output logic        romnram,
	output zx_regs_t    regs
);

	z80_bus_t    bus;
	z80_strobe_t strobe;
	dos_state_t  dos_state;
	logic        vdos_on;
	logic        dos_on;
	logic        dos_off;

	////////////////////////////////////////
	// z80 bus front end
	////////////////////////////////////////

	zsignals zsignals (
		.fclk   (fclk),
		.arst_n (arst_n),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d_in   (d_in),
		.bus    (bus),
		.strobe (strobe)
	);

	zports zports (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.bus       (bus),
		.strobe    (strobe),
		.dos_state (dos_state),
		.regs      (regs),
		.d_out     (d_out),
		.d_oe      (d_oe),
		.vdos_on   (vdos_on)
	);

	////////////////////////////////////////
	// memory map and rom switching
	////////////////////////////////////////

	zpager zpager (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.bus       (bus),
		.strobe    (strobe),
		.regs      (regs),
		.dos_state (dos_state),
		.page      (page),
		.romnram   (romnram),
		.dos_on    (dos_on),
		.dos_off   (dos_off)
	);

	zdos zdos (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.dos_on    (dos_on),
		.dos_off   (dos_off),
		.vdos_on   (vdos_on),
		.dos_state (dos_state)
	);

	// frame interrupt
	zint zint (
		.fclk   (fclk),
		.arst_n (arst_n),
		.strobe (strobe),
		.int_n  (int_n)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic fclk
);

	// period of 4 time units
	initial begin
		fclk = 1'b0;
		forever begin
			#2 fclk = ~fclk;
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_zx_properties.sv
`default_nettype none

`include "zx_consts.svh"

module tb_zx_properties import zx_pkg::*; (
	input logic       fclk,
	input logic       arst_n,
	input logic       iorq_n,
	input logic       rd_n,
	input logic       d_oe,
	input logic       int_n,
	input dos_state_t dos_state
);

	logic [7:0] low_cnt;

	// cycles spent with int_n low
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			low_cnt <= '0;
		end else if (int_n) begin
			low_cnt <= '0;
		end else begin
			low_cnt <= low_cnt + 8'd1;
		end
	end

	// readback follows an io read on the pins, through the synchroniser and one register
	oe_needs_read: assert property (@(posedge fclk) disable iff (!arst_n)
		d_oe |-> $past(!iorq_n && !rd_n, 3))
		else $error("d_oe is high without an active io read");

	int_len_limit: assert property (@(posedge fclk) disable iff (!arst_n)
		int'(low_cnt) <= `ZX_INT_LEN)
		else $error("int_n stayed low longer than the interrupt length");

	// vdos is only reachable from dos
	no_basic_to_vdos: assert property (@(posedge fclk) disable iff (!arst_n)
		(dos_state == ST_VDOS) |-> ($past(dos_state) != ST_BASIC))
		else $error("state moved from basic straight to vdos");

endmodule

bind zx_top tb_zx_properties props (
	.fclk      (fclk),
	.arst_n    (arst_n),
	.iorq_n    (iorq_n),
	.rd_n      (rd_n),
	.d_oe      (d_oe),
	.int_n     (int_n),
	.dos_state (dos_state)
);

`default_nettype wire

// File: testbench/tb_zx.sv
`default_nettype none

`include "zx_consts.svh"

module tb_zx import zx_pkg::*; ();

	typedef enum logic [1:0] {
		IO_WR,
		IO_RD,
		MEM_RD,
		FETCH
	} access_t;

	// one bus access and the state expected after it
	typedef struct packed {
		access_t     kind;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  page;
		logic        romnram;
		zx_regs_t    regs;
		logic        d_oe;
		logic [7:0]  d_out;
	} row_t;

	logic        fclk;
	logic        arst_n;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic [7:0]  d_out;
	logic        d_oe;
	logic        int_n;
	logic [7:0]  page;
	logic        romnram;
	zx_regs_t    regs;
	row_t        rows [$];
	int          cycles;
	int          low_len;

	tb_clock clock_gen (.fclk(fclk));

	zx_top dut (
		.fclk    (fclk),
		.arst_n  (arst_n),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.a       (a),
		.d_in    (d_in),
		.d_out   (d_out),
		.d_oe    (d_oe),
		.int_n   (int_n),
		.page    (page),
		.romnram (romnram),
		.regs    (regs)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// inputs change and outputs are sampled here
	task automatic tick();
		@(posedge fclk);
		#1;
	endtask

	task automatic idle_bus();
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		a      = 16'h0000;
		d_in   = 8'h00;
	endtask

	task automatic drive_access(input access_t kind, input logic [15:0] addr,
		input logic [7:0] data);
		a    = addr;
		d_in = data;
		case (kind)
			IO_WR: begin
				iorq_n = 1'b0;
				wr_n   = 1'b0;
			end
			IO_RD: begin
				iorq_n = 1'b0;
				rd_n   = 1'b0;
			end
			MEM_RD: begin
				mreq_n = 1'b0;
				rd_n   = 1'b0;
			end
			default: begin
				mreq_n = 1'b0;
				rd_n   = 1'b0;
				m1_n   = 1'b0;
			end
		endcase
	endtask

	task automatic wait_int(input logic level, input int limit, output int count);
		count = 0;
		while (int_n !== level && count < limit) begin
			tick();
			count++;
		end
		if (int_n !== level) begin
			$display("timeout: int_n did not reach %0b within %0d cycles", level, limit);
			stop_run();
		end
	endtask

	task automatic check_regs(input zx_regs_t got, input zx_regs_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s regs %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_page(input logic [7:0] got_page, input logic got_rom,
		input logic [7:0] exp_page, input logic exp_rom, input string what);
		if (got_page !== exp_page || got_rom !== exp_rom) begin
			$display("mismatch at %0t: %s page %0d romnram %b, expected page %0d romnram %b",
				$time, what, got_page, got_rom, exp_page, exp_rom);
			stop_run();
		end
	endtask

	// d_out only matters while d_oe is expected high
	task automatic check_data(input logic [7:0] got_d, input logic got_oe,
		input logic [7:0] exp_d, input logic exp_oe, input string what);
		if (got_oe !== exp_oe || (exp_oe && got_d !== exp_d)) begin
			$display("mismatch at %0t: %s d_out %h d_oe %b, expected d_out %h d_oe %b",
				$time, what, got_d, got_oe, exp_d, exp_oe);
			stop_run();
		end
	endtask

	task automatic check_interval(input int got, input int lo, input int hi,
		input string what);
		if (got < lo || got > hi) begin
			$display("mismatch at %0t: %s took %0d cycles, expected %0d to %0d",
				$time, what, got, lo, hi);
			stop_run();
		end
	endtask

	function automatic zx_regs_t regs_of(input int border, input int beep, input int ram_page,
		input int screen, input int rom_sel, input int lock, input int turbo, input int vdrive);
		zx_regs_t r;
		r.border   = 3'(border);
		r.beep     = 1'(beep);
		r.ram_page = 3'(ram_page);
		r.screen   = 1'(screen);
		r.rom_sel  = 1'(rom_sel);
		r.lock     = 1'(lock);
		r.turbo    = 2'(turbo);
		r.vdrive   = 1'(vdrive);
		return r;
	endfunction

	function automatic void add_row(input access_t kind, input int addr, input int data,
		input int pg, input int rom, input zx_regs_t exp_regs, input int oe, input int dout);
		row_t r;
		r.kind    = kind;
		r.addr    = 16'(addr);
		r.data    = 8'(data);
		r.page    = 8'(pg);
		r.romnram = 1'(rom);
		r.regs    = exp_regs;
		r.d_oe    = 1'(oe);
		r.d_out   = 8'(dout);
		rows.push_back(r);
	endfunction

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////

	task automatic load_table();
		// kind, addr, data, page, romnram, regs, d_oe, d_out
		add_row(IO_WR,  'h00FE, 'h15, 0, 1, regs_of(5, 1, 0, 0, 0, 0, 0, 0), 0, 0);
		add_row(MEM_RD, 'h4000, 'h00, 5, 0, regs_of(5, 1, 0, 0, 0, 0, 0, 0), 0, 0);
		add_row(MEM_RD, 'h8000, 'h00, 2, 0, regs_of(5, 1, 0, 0, 0, 0, 0, 0), 0, 0);
		add_row(IO_WR,  'h7FFD, 'h13, 2, 0, regs_of(5, 1, 3, 0, 1, 0, 0, 0), 0, 0);
		add_row(MEM_RD, 'hC000, 'h00, 3, 0, regs_of(5, 1, 3, 0, 1, 0, 0, 0), 0, 0);
		add_row(IO_WR,  'h20AF, 'h82, 3, 0, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 0, 0);
		add_row(IO_RD,  'h20AF, 'h00, 3, 0, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 1, 'h82);
		add_row(IO_RD,  'h00FE, 'h00, 3, 0, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 0, 0);
		// dos trap, then vdos through the fdc port
		add_row(FETCH,  'h3D00, 'h00, 3, 1, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 0, 0);
		add_row(IO_RD,  'h001F, 'h00, 3, 1, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 0, 0);
		add_row(MEM_RD, 'h0000, 'h00, 4, 1, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 0, 0);
		add_row(FETCH,  'h8000, 'h00, 2, 0, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 0, 0);
		add_row(MEM_RD, 'h0000, 'h00, 1, 1, regs_of(5, 1, 3, 0, 1, 0, 2, 1), 0, 0);
		// same trap with vdrive off
		add_row(IO_WR,  'h20AF, 'h00, 1, 1, regs_of(5, 1, 3, 0, 1, 0, 0, 0), 0, 0);
		add_row(FETCH,  'h3D00, 'h00, 3, 1, regs_of(5, 1, 3, 0, 1, 0, 0, 0), 0, 0);
		add_row(IO_RD,  'h001F, 'h00, 3, 1, regs_of(5, 1, 3, 0, 1, 0, 0, 0), 0, 0);
		add_row(MEM_RD, 'h0000, 'h00, 3, 1, regs_of(5, 1, 3, 0, 1, 0, 0, 0), 0, 0);
		add_row(FETCH,  'hC000, 'h00, 3, 0, regs_of(5, 1, 3, 0, 1, 0, 0, 0), 0, 0);
		// lock, then a write that must be ignored
		add_row(IO_WR,  'h7FFD, 'h26, 3, 0, regs_of(5, 1, 6, 0, 0, 1, 0, 0), 0, 0);
		add_row(IO_WR,  'h7FFD, 'h11, 3, 0, regs_of(5, 1, 6, 0, 0, 1, 0, 0), 0, 0);
		add_row(MEM_RD, 'hC000, 'h00, 6, 0, regs_of(5, 1, 6, 0, 0, 1, 0, 0), 0, 0);
		add_row(FETCH,  'h3D00, 'h00, 0, 1, regs_of(5, 1, 6, 0, 0, 1, 0, 0), 0, 0);
		add_row(MEM_RD, 'h0000, 'h00, 0, 1, regs_of(5, 1, 6, 0, 0, 1, 0, 0), 0, 0);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		arst_n = 1'b0;
		idle_bus();
		load_table();
		repeat (16) tick();
		arst_n = 1'b1;

		check_regs(regs, regs_of(0, 0, 0, 0, 0, 0, 0, 0), "after reset");
		check_page(page, romnram, 8'h00, 1'b1, "after reset");
		check_data(d_out, d_oe, 8'h00, 1'b0, "after reset");

		// frame interrupt period and pulse length
		wait_int(1'b0, `ZX_FRAME_LEN + 10, cycles);
		check_interval(cycles, `ZX_FRAME_LEN - 5, `ZX_FRAME_LEN + 5, "first int_n fall");
		wait_int(1'b1, `ZX_INT_LEN + 10, low_len);
		check_interval(low_len, `ZX_INT_LEN - 5, `ZX_INT_LEN + 5, "int_n pulse");
		wait_int(1'b0, `ZX_FRAME_LEN + 10, cycles);
		check_interval(low_len + cycles, `ZX_FRAME_LEN - 5, `ZX_FRAME_LEN + 5,
			"int_n period");

		// acknowledge a few cycles into the pulse
		repeat (4) tick();
		iorq_n = 1'b0;
		m1_n   = 1'b0;
		wait_int(1'b1, 10, cycles);
		check_interval(cycles, 1, 5, "int_n end after acknowledge");
		idle_bus();
		repeat (4) tick();

		foreach (rows[i]) begin
			drive_access(rows[i].kind, rows[i].addr, rows[i].data);
			repeat (8) tick();
			check_regs(regs, rows[i].regs, $sformatf("row %0d", i));
			check_page(page, romnram, rows[i].page, rows[i].romnram, $sformatf("row %0d", i));
			check_data(d_out, d_oe, rows[i].d_out, rows[i].d_oe, $sformatf("row %0d", i));
			idle_bus();
			repeat (4) tick();
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/zx_pkg.sv
logic/zsignals.sv
ports/zports.sv
memory/zpager.sv
memory/zdos.sv
logic/zint.sv
logic/zx_top.sv
testbench/tb_clock.sv
testbench/tb_zx_properties.sv
testbench/tb_zx.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_zx -f filelist.f -o tb_zx_sim \
	&& ./obj_dir/tb_zx_sim | tee /dev/stderr | grep -q "^No errors$" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
